// File: common/udp_rx_pkg.sv
package udp_rx_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [15:0] len16_t;

	localparam byte_t preamble_byte = 8'h55;
	localparam byte_t sfd_byte = 8'hd5;
	localparam len16_t ethertype_ipv4 = 16'h0800;
	localparam int udp_hdr_bytes = 8;
	localparam int default_ram_addr_w = 9;

	// header summary of one accepted frame
	typedef struct packed {
		mac_addr_t src_mac;
		ip_addr_t src_ip;
		ip_addr_t dst_ip;
		udp_port_t src_port;
		udp_port_t dst_port;
		len16_t payload_len; // udp length minus header
	} frame_info_t;

	typedef struct packed {
		byte_t data;
		logic last;
	} pay_beat_t;

	// ram_wr_t field order: addr, then data (word_t)
	// width of addr comes from ram_addr_w, so the type lives in each user module

	typedef enum logic [3:0] {
		idle,
		preamble,
		sfd,
		mac,
		ethertype,
		ip_hdr,
		udp_hdr,
		payload,
		drain
	} parse_state_t;

endpackage

// File: udp_rx/udp_frame_parser.sv
`timescale 1ns/1ps

module udp_frame_parser #(
	parameter udp_rx_pkg::mac_addr_t local_mac = 48'h000a_3501_fec0
) (
	input logic clk,
	input logic arst_n,
	input logic rx_dv,
	input udp_rx_pkg::byte_t rx_byte,
	output udp_rx_pkg::pay_beat_t pay_beat,
	output logic pay_valid,
	output logic frame_ok,
	output logic frame_drop,
	output udp_rx_pkg::frame_info_t info
);
	import udp_rx_pkg::*;

	parse_state_t state;
	parse_state_t state_nxt;
	len16_t cnt; // byte index within the current field
	len16_t field_last;
	len16_t udp_len;
	logic at_end;
	logic drop;
	logic beat;
	logic [87:0] hdr_sr; // last 11 bytes seen
	frame_info_t pend; // fields of the frame in flight
	len16_t beat_run; // back to back beats before this one

	assign at_end = (cnt == field_last);
	assign beat = (state == payload) && rx_dv;
	assign udp_len = hdr_sr[23:8];

	always_comb begin
		case (state)
			preamble: field_last = 16'd5; // first 0x55 was taken in idle
			mac: field_last = 16'd11;
			ethertype: field_last = 16'd1;
			ip_hdr: field_last = 16'd19;
			udp_hdr: field_last = len16_t'(udp_hdr_bytes - 1);
			payload: field_last = pend.payload_len - 16'd1;
			default: field_last = '0;
		endcase
	end

	always_comb begin
		state_nxt = state;
		drop = 1'b0;
		case (state)
			idle: begin
				if (rx_dv && rx_byte == preamble_byte)
					state_nxt = preamble;
			end
			preamble: begin
				if (!rx_dv || rx_byte != preamble_byte)
					state_nxt = idle;
				else if (at_end)
					state_nxt = sfd;
			end
			sfd: begin
				// a longer preamble just keeps us here
				if (!rx_dv || (rx_byte != sfd_byte && rx_byte != preamble_byte))
					state_nxt = idle;
				else if (rx_byte == sfd_byte)
					state_nxt = mac;
			end
			mac, ethertype, ip_hdr, udp_hdr, payload: begin
				if (!rx_dv) begin
					state_nxt = idle; // cut short
					drop = 1'b1;
				end else if (at_end) begin
					case (state)
						mac: begin
							if (hdr_sr[87:40] == local_mac) begin
								state_nxt = ethertype;
							end else begin
								state_nxt = drain;
								drop = 1'b1;
							end
						end
						ethertype: begin
							if ({hdr_sr[7:0], rx_byte} == ethertype_ipv4) begin
								state_nxt = ip_hdr;
							end else begin
								state_nxt = drain;
								drop = 1'b1;
							end
						end
						ip_hdr: state_nxt = udp_hdr;
						udp_hdr: begin
							if (udp_len < len16_t'(udp_hdr_bytes + 1)) begin
								state_nxt = drain; // empty payload
								drop = 1'b1;
							end else begin
								state_nxt = payload;
							end
						end
						default: state_nxt = drain; // payload done, skip fcs
					endcase
				end
			end
			drain: begin
				if (!rx_dv)
					state_nxt = idle;
			end
			default: state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			cnt <= '0;
			pay_valid <= 1'b0;
			frame_ok <= 1'b0;
			frame_drop <= 1'b0;
		end else begin
			state <= state_nxt;
			cnt <= (state_nxt == state) ? cnt + 16'd1 : '0;
			pay_valid <= beat;
			frame_ok <= beat && at_end;
			frame_drop <= drop;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_dv)
			hdr_sr <= {hdr_sr[79:0], rx_byte};
		if (state == mac && rx_dv && at_end)
			pend.src_mac <= {hdr_sr[39:0], rx_byte};
		if (state == ip_hdr && rx_dv && at_end) begin
			pend.src_ip <= hdr_sr[55:24]; // bytes 12..15
			pend.dst_ip <= {hdr_sr[23:0], rx_byte};
		end
		if (state == udp_hdr && rx_dv && at_end) begin
			pend.src_port <= hdr_sr[55:40];
			pend.dst_port <= hdr_sr[39:24];
			pend.payload_len <= udp_len - len16_t'(udp_hdr_bytes);
		end
		pay_beat.data <= rx_byte;
		pay_beat.last <= at_end;
		if (beat && at_end)
			info <= pend;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			beat_run <= '0;
		else
			beat_run <= pay_valid ? beat_run + 16'd1 : '0;
	end

	a_beat_in_payload: assert property (@(posedge clk) disable iff (!arst_n)
		pay_valid && !pay_beat.last |-> state == payload);

	a_ok_on_last: assert property (@(posedge clk) disable iff (!arst_n)
		frame_ok |-> pay_valid && pay_beat.last && beat_run == info.payload_len - 16'd1);

endmodule

// File: udp_rx/payload_word_packer.sv
`timescale 1ns/1ps

module payload_word_packer #(
	parameter int ram_addr_w = udp_rx_pkg::default_ram_addr_w
) (
	input logic clk,
	input logic arst_n,
	input udp_rx_pkg::pay_beat_t pay_beat,
	input logic pay_valid,
	input logic frame_ok,
	output logic [ram_addr_w+$bits(udp_rx_pkg::word_t)-1:0] wr,
	output logic wr_en,
	output logic frame_done,
	output udp_rx_pkg::len16_t word_count
);
	import udp_rx_pkg::*;

	typedef struct packed {
		logic [ram_addr_w-1:0] addr;
		word_t data;
	} ram_wr_t;

	ram_wr_t wr_q;
	logic beat_d; // previous cycle had a beat
	logic [1:0] phase;
	logic [1:0] phase_cur;
	logic [ram_addr_w-1:0] addr;
	logic [ram_addr_w-1:0] addr_cur;
	logic [23:0] held; // up to three earlier bytes
	logic word_end;
	word_t word_out;

	assign wr = wr_q;

	always_comb begin
		// beats of one frame are back to back, so a gap means a new frame
		phase_cur = beat_d ? phase : 2'd0;
		addr_cur = beat_d ? addr : '0;
		word_end = pay_valid && (pay_beat.last || phase_cur == 2'd3);
		word_out = {held, pay_beat.data} << (8 * (3 - phase_cur)); // zero pad low bytes
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beat_d <= 1'b0;
			phase <= '0;
			addr <= '0;
			wr_en <= 1'b0;
			frame_done <= 1'b0;
			word_count <= '0;
		end else begin
			beat_d <= pay_valid;
			wr_en <= word_end;
			frame_done <= frame_ok;
			if (pay_valid) begin
				phase <= pay_beat.last ? 2'd0 : phase_cur + 2'd1;
				if (pay_beat.last)
					addr <= '0;
				else if (word_end)
					addr <= addr_cur + 1'b1;
				else
					addr <= addr_cur;
			end
			if (frame_ok)
				word_count <= len16_t'(addr_cur) + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (pay_valid)
			held <= {held[15:0], pay_beat.data};
		if (word_end) begin
			wr_q.addr <= addr_cur;
			wr_q.data <= word_out;
		end
	end

	// frame longer than the ram would wrap onto word 0
	a_no_wrap: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en && !frame_done |-> wr_q.addr != '1);

endmodule

// File: source/payload_ram.sv
`timescale 1ns/1ps

module payload_ram #(
	parameter int ram_addr_w = udp_rx_pkg::default_ram_addr_w
) (
	input logic clk,
	input logic [ram_addr_w+$bits(udp_rx_pkg::word_t)-1:0] wr,
	input logic wr_en,
	input logic [ram_addr_w-1:0] rd_addr,
	output udp_rx_pkg::word_t rd_data
);
	import udp_rx_pkg::*;

	typedef struct packed {
		logic [ram_addr_w-1:0] addr;
		word_t data;
	} ram_wr_t;

	ram_wr_t wr_s;
	word_t mem [2**ram_addr_w];

	assign wr_s = wr;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_s.addr] <= wr_s.data;
	end

	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr]; // one cycle read latency
	end

endmodule

// File: source/rx_frame_stats.sv
`timescale 1ns/1ps

module rx_frame_stats (
	input logic clk,
	input logic arst_n,
	input logic frame_done,
	input logic frame_drop,
	output udp_rx_pkg::len16_t good_frames,
	output udp_rx_pkg::len16_t dropped_frames
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			good_frames <= '0;
			dropped_frames <= '0;
		end else begin
			if (frame_done && !(&good_frames))
				good_frames <= good_frames + 16'd1; // holds at max
			if (frame_drop && !(&dropped_frames))
				dropped_frames <= dropped_frames + 16'd1;
		end
	end

	// a frame either completes or is dropped, never both at once
	a_one_outcome: assert property (@(posedge clk) disable iff (!arst_n)
		!(frame_done && frame_drop));

endmodule

// File: source/udp_rx_top.sv
`timescale 1ns/1ps

module udp_rx_top #(
	parameter udp_rx_pkg::mac_addr_t local_mac = 48'h000a_3501_fec0,
	parameter int ram_addr_w = udp_rx_pkg::default_ram_addr_w
) (
	input logic clk,
	input logic arst_n,
	input logic rx_dv,
	input udp_rx_pkg::byte_t rx_byte,
	input logic [ram_addr_w-1:0] rd_addr,
	output udp_rx_pkg::word_t rd_data,
	output udp_rx_pkg::frame_info_t info,
	output logic frame_done,
	output udp_rx_pkg::len16_t word_count,
	output udp_rx_pkg::len16_t good_frames,
	output udp_rx_pkg::len16_t dropped_frames
);
	import udp_rx_pkg::*;

	pay_beat_t pay_beat;
	logic pay_valid;
	logic frame_ok;
	logic frame_drop;
	logic [ram_addr_w+$bits(word_t)-1:0] wr; // packed ram_wr_t
	logic wr_en;

	udp_frame_parser #(
		.local_mac(local_mac)
	) parser_i (
		.clk(clk),
		.arst_n(arst_n),
		.rx_dv(rx_dv),
		.rx_byte(rx_byte),
		.pay_beat(pay_beat),
		.pay_valid(pay_valid),
		.frame_ok(frame_ok),
		.frame_drop(frame_drop),
		.info(info)
	);

	payload_word_packer #(
		.ram_addr_w(ram_addr_w)
	) packer_i (
		.clk(clk),
		.arst_n(arst_n),
		.pay_beat(pay_beat),
		.pay_valid(pay_valid),
		.frame_ok(frame_ok),
		.wr(wr),
		.wr_en(wr_en),
		.frame_done(frame_done),
		.word_count(word_count)
	);

	payload_ram #(
		.ram_addr_w(ram_addr_w)
	) ram_i (
		.clk(clk),
		.wr(wr),
		.wr_en(wr_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	rx_frame_stats stats_i (
		.clk(clk),
		.arst_n(arst_n),
		.frame_done(frame_done),
		.frame_drop(frame_drop),
		.good_frames(good_frames),
		.dropped_frames(dropped_frames)
	);

endmodule

// File: test/frame_table.svh
// one row per test frame
// abort_at counts bytes after the sfd before rx_dv drops, 0 means a full frame
// noise sends a random burst and a short preamble ahead of the frame

typedef struct packed {
	mac_addr_t dst_mac;
	len16_t ethertype;
	ip_addr_t src_ip;
	ip_addr_t dst_ip;
	udp_port_t src_port;
	udp_port_t dst_port;
	len16_t pay_len;
	len16_t abort_at;
	logic noise;
	logic accept;
} frame_row_t;

localparam int n_rows = 9;
localparam mac_addr_t board_mac = 48'h000a_3501_fec0;
localparam mac_addr_t peer_mac = 48'h0200_1122_3344;

frame_row_t rows [n_rows];

task automatic load_frame_table();
	rows[0] = '{board_mac, 16'h0800, 32'hc0a8_0101, 32'hc0a8_010a, 16'd5000, 16'd6000,
		16'd1, 16'd0, 1'b0, 1'b1};
	rows[1] = '{board_mac, 16'h0800, 32'hc0a8_0102, 32'hc0a8_010a, 16'd1234, 16'd80,
		16'd4, 16'd0, 1'b0, 1'b1};
	rows[2] = '{48'h000a_3501_fec1, 16'h0800, 32'h0a00_0001, 32'hc0a8_010a, 16'd7, 16'd7,
		16'd8, 16'd0, 1'b0, 1'b0}; // wrong mac
	rows[3] = '{board_mac, 16'h0800, 32'h0a00_0002, 32'hc0a8_010a, 16'hbeef, 16'h1f90,
		16'd5, 16'd0, 1'b1, 1'b1};
	rows[4] = '{board_mac, 16'h86dd, 32'h0a00_0003, 32'hc0a8_010a, 16'd1, 16'd2,
		16'd8, 16'd0, 1'b0, 1'b0}; // not ipv4
	rows[5] = '{board_mac, 16'h0800, 32'h0a00_0004, 32'hc0a8_010a, 16'd3, 16'd4,
		16'd12, 16'd20, 1'b0, 1'b0}; // cut in ip header
	rows[6] = '{board_mac, 16'h0800, 32'hac10_0005, 32'hc0a8_010a, 16'd4321, 16'd53,
		16'd7, 16'd0, 1'b0, 1'b1};
	rows[7] = '{board_mac, 16'h0800, 32'hac10_0006, 32'hc0a8_010a, 16'd9, 16'd10,
		16'd16, 16'd48, 1'b0, 1'b0}; // cut in payload
	rows[8] = '{board_mac, 16'h0800, 32'hac10_0007, 32'hc0a8_010a, 16'hffff, 16'h0001,
		16'd64, 16'd0, 1'b1, 1'b1};
endtask

// File: test/udp_rx_tb.sv
`timescale 1ns/1ps

module udp_rx_tb;
	import udp_rx_pkg::*;

	`include "frame_table.svh"

	localparam int ram_addr_w = 9;
	localparam int gap_cycles = 12;

	logic clk;
	logic arst_n;
	logic rx_dv;
	byte_t rx_byte;
	logic [ram_addr_w-1:0] rd_addr;
	word_t rd_data;
	frame_info_t info;
	logic frame_done;
	len16_t word_count;
	len16_t good_frames;
	len16_t dropped_frames;

	integer seed = 32'hb91f;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 1000000;
	int done_count = 0;
	frame_info_t seen_info;
	len16_t seen_words;
	byte_t frame_q[$];
	byte_t pay_q[$];

	udp_rx_top #(
		.local_mac(board_mac),
		.ram_addr_w(ram_addr_w)
	) dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.rx_dv(rx_dv),
		.rx_byte(rx_byte),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.info(info),
		.frame_done(frame_done),
		.word_count(word_count),
		.good_frames(good_frames),
		.dropped_frames(dropped_frames)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run passed %0d cycles without finishing", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// outputs settle after the rising edge
	always @(negedge clk) begin
		if (frame_done === 1'b1) begin
			done_count <= done_count + 1;
			seen_info <= info;
			seen_words <= word_count;
		end
	end

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL at %0t: %s got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic send_byte(input byte_t b);
		rx_dv = 1'b1;
		rx_byte = b;
		@(negedge clk);
	endtask

	task automatic idle(input int n);
		rx_dv = 1'b0;
		rx_byte = 8'h00;
		repeat (n) @(negedge clk);
	endtask

	task automatic send_noise();
		repeat (8) send_byte(byte_t'($random(seed)));
		idle(2);
		repeat (4) send_byte(preamble_byte);
		send_byte(sfd_byte); // sfd too early
		idle(2);
	endtask

	task automatic build_frame(input frame_row_t r);
		len16_t udp_len;
		udp_len = r.pay_len + 16'd8;
		frame_q.delete();
		pay_q.delete();
		for (int i = 5; i >= 0; i--) frame_q.push_back(r.dst_mac[8*i +: 8]);
		for (int i = 5; i >= 0; i--) frame_q.push_back(peer_mac[8*i +: 8]);
		frame_q.push_back(r.ethertype[15:8]);
		frame_q.push_back(r.ethertype[7:0]);
		frame_q.push_back(8'h45);
		frame_q.push_back(8'h00);
		frame_q.push_back(8'((udp_len + 16'd20) >> 8));
		frame_q.push_back(8'(udp_len + 16'd20));
		repeat (4) frame_q.push_back(8'h00); // id, flags
		frame_q.push_back(8'd64);
		frame_q.push_back(8'd17);
		repeat (2) frame_q.push_back(8'h00);
		for (int i = 3; i >= 0; i--) frame_q.push_back(r.src_ip[8*i +: 8]);
		for (int i = 3; i >= 0; i--) frame_q.push_back(r.dst_ip[8*i +: 8]);
		frame_q.push_back(r.src_port[15:8]);
		frame_q.push_back(r.src_port[7:0]);
		frame_q.push_back(r.dst_port[15:8]);
		frame_q.push_back(r.dst_port[7:0]);
		frame_q.push_back(udp_len[15:8]);
		frame_q.push_back(udp_len[7:0]);
		repeat (2) frame_q.push_back(8'h00);
		for (int i = 0; i < r.pay_len; i++) begin
			pay_q.push_back(byte_t'($random(seed)));
			frame_q.push_back(pay_q[i]);
		end
	endtask

	task automatic send_frame(input frame_row_t r);
		repeat (7) send_byte(preamble_byte);
		send_byte(sfd_byte);
		for (int i = 0; i < frame_q.size(); i++) begin
			if (r.abort_at != 0 && i == r.abort_at)
				break;
			send_byte(frame_q[i]);
		end
		if (r.abort_at == 0)
			repeat (4) send_byte(byte_t'($random(seed))); // fcs, not checked
		idle(gap_cycles);
	endtask

	task automatic read_back(input int n_words);
		word_t exp;
		int idx;
		for (int w = 0; w < n_words; w++) begin
			exp = '0;
			for (int j = 0; j < 4; j++) begin
				idx = 4 * w + j;
				if (idx < pay_q.size())
					exp[8*(3-j) +: 8] = pay_q[idx];
			end
			rd_addr = w[ram_addr_w-1:0];
			@(negedge clk);
			check(rd_data, exp, $sformatf("ram word %0d", w));
		end
	endtask

	initial begin
		int limit;
		int exp_good;
		int exp_drop;
		int n_words;
		int done_before;
		int err_before;
		len16_t good_before;
		len16_t drop_before;

		load_frame_table();
		limit = 0;
		for (int i = 0; i < n_rows; i++)
			limit += 17 + 8 + 42 + rows[i].pay_len + 4 + gap_cycles + rows[i].pay_len / 4 + 2;
		cycle_limit = 2 * limit;
		exp_good = 0;
		exp_drop = 0;

		rx_dv = 1'b0;
		rx_byte = 8'h00;
		rd_addr = '0;
		arst_n = 1'b0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		idle(2);

		for (int i = 0; i < n_rows; i++) begin
			err_before = errors;
			done_before = done_count;
			good_before = good_frames;
			drop_before = dropped_frames;
			n_words = (rows[i].pay_len + 3) / 4;
			build_frame(rows[i]);
			if (rows[i].noise) begin
				send_noise();
				check(good_frames, good_before, "good count after noise");
				check(dropped_frames, drop_before, "drop count after noise");
			end
			send_frame(rows[i]);
			if (rows[i].accept) begin
				exp_good++;
				check(done_count, done_before + 1, "frame_done pulses");
				check(seen_info.src_mac, peer_mac, "src_mac");
				check(seen_info.src_ip, rows[i].src_ip, "src_ip");
				check(seen_info.dst_ip, rows[i].dst_ip, "dst_ip");
				check(seen_info.src_port, rows[i].src_port, "src_port");
				check(seen_info.dst_port, rows[i].dst_port, "dst_port");
				check(seen_info.payload_len, rows[i].pay_len, "payload_len");
				check(seen_words, n_words, "word_count");
				check(good_frames, good_before + 16'd1, "good_frames step");
				check(dropped_frames, drop_before, "dropped_frames held");
				read_back(n_words);
			end else begin
				exp_drop++;
				check(done_count, done_before, "no frame_done on drop");
				check(good_frames, good_before, "good_frames held");
				check(dropped_frames, drop_before + 16'd1, "dropped_frames step");
			end
			$display("frame %0d: %s, %0d payload bytes, %0d errors", i,
				rows[i].accept ? "accept" : "drop", rows[i].pay_len, errors - err_before);
		end

		check(good_frames, exp_good, "final good_frames");
		check(dropped_frames, exp_drop, "final dropped_frames");
		$display("frames %0d, checks %0d, errors %0d", n_rows, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+test
common/udp_rx_pkg.sv
udp_rx/udp_frame_parser.sv
udp_rx/payload_word_packer.sv
source/payload_ram.sv
source/rx_frame_stats.sv
source/udp_rx_top.sv
test/udp_rx_tb.sv
